// ==== common/merge_pkg.sv ====
package merge_pkg;

   localparam int DATA_WIDTH = 32;              // One record
   localparam int KEY_WIDTH  = 24;              // Sort key, low bits of a record
   localparam int BEAT_WIDTH = 2 * DATA_WIDTH;  // Two records per beat

   localparam int FIFO_DEPTH = 16;

   // Head pop to output FIFO write, in cycles
   localparam int PIPE_DEPTH = 4;

   typedef enum logic [2:0] {
      IDLE,
      MERGE,
      DRAIN_A,
      DRAIN_B,
      FLUSH,
      MARK
   } ctrl_state_t;

   function automatic logic [KEY_WIDTH-1:0] rec_key(input logic [DATA_WIDTH-1:0] rec);
      return rec[KEY_WIDTH-1:0];
   endfunction

   // Key of record 0, the smaller one of a beat
   function automatic logic [KEY_WIDTH-1:0] first_key(input logic [BEAT_WIDTH-1:0] beat);
      return rec_key(beat[DATA_WIDTH-1:0]);
   endfunction

   // Both records zero ends a stream
   function automatic logic is_marker(input logic [BEAT_WIDTH-1:0] beat);
      return (beat == '0);
   endfunction

endpackage

// ==== hdl/beat_fifo.sv ====
`timescale 1ns/1ps

module beat_fifo #(
   parameter int WIDTH  = merge_pkg::BEAT_WIDTH,
   parameter int DEPTH  = merge_pkg::FIFO_DEPTH,
   parameter int ALMOST = merge_pkg::FIFO_DEPTH - merge_pkg::PIPE_DEPTH
) (
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic             i_push,
   input  logic [WIDTH-1:0] i_data,
   input  logic             i_pop,
   output logic [WIDTH-1:0] o_data,
   output logic             o_empty,
   output logic             o_full,
   output logic             o_almost_full
);

   localparam int PW = $clog2(DEPTH);
   localparam int CW = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PW-1:0]    rd_ptr;
   logic [PW-1:0]    wr_ptr;
   logic [CW-1:0]    count;

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (i_pop) begin
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({i_push, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // Both or neither
         endcase
      end
   end

   // Fall-through head
   assign o_data = mem[rd_ptr];

   assign o_empty       = (count == '0);
   assign o_full        = (count == CW'(DEPTH));
   assign o_almost_full = (count >= CW'(ALMOST));

endmodule

// ==== hdl/bitonic_stage.sv ====
`timescale 1ns/1ps

module bitonic_stage #(
   parameter int DATA_WIDTH = merge_pkg::DATA_WIDTH,
   parameter int KEY_WIDTH  = merge_pkg::KEY_WIDTH,
   parameter int STAGE      = 0
) (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic                    i_stall,
   input  logic                    i_valid,
   input  logic [2*DATA_WIDTH-1:0] i_lo,
   input  logic [2*DATA_WIDTH-1:0] i_hi,
   output logic                    o_valid,
   output logic [2*DATA_WIDTH-1:0] o_lo,
   output logic [2*DATA_WIDTH-1:0] o_hi
);

   // Positions 0..3 of the four-record sequence
   logic [DATA_WIDTH-1:0] p0;
   logic [DATA_WIDTH-1:0] p1;
   logic [DATA_WIDTH-1:0] p2;
   logic [DATA_WIDTH-1:0] p3;
   logic [DATA_WIDTH-1:0] q0;
   logic [DATA_WIDTH-1:0] q1;
   logic [DATA_WIDTH-1:0] q2;
   logic [DATA_WIDTH-1:0] q3;

   function automatic logic key_le(input logic [DATA_WIDTH-1:0] a,
                                   input logic [DATA_WIDTH-1:0] b);
      return a[KEY_WIDTH-1:0] <= b[KEY_WIDTH-1:0];
   endfunction

   assign {p1, p0} = i_lo;
   assign {p3, p2} = i_hi;

   generate
      if (STAGE == 0) begin : g_cross
         // Compare across halves, 0 with 2 and 1 with 3
         always_comb begin
            q0 = key_le(p0, p2) ? p0 : p2;
            q2 = key_le(p0, p2) ? p2 : p0;
            q1 = key_le(p1, p3) ? p1 : p3;
            q3 = key_le(p1, p3) ? p3 : p1;
         end
      end else begin : g_within
         // Sort each half
         always_comb begin
            q0 = key_le(p0, p1) ? p0 : p1;
            q1 = key_le(p0, p1) ? p1 : p0;
            q2 = key_le(p2, p3) ? p2 : p3;
            q3 = key_le(p2, p3) ? p3 : p2;
         end
      end
   endgenerate

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_valid <= 1'b0;
      end else begin
         o_valid <= i_valid & ~i_stall;
      end
   end

   // Data holds through empty slots
   always_ff @(posedge i_clk) begin
      if (!i_stall) begin
         o_lo <= {q1, q0};
         o_hi <= {q3, q2};
      end
   end

endmodule

// ==== hdl/merge_control.sv ====
`timescale 1ns/1ps

module merge_control (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_a_empty,
   input  logic i_b_empty,
   input  logic i_a_end,
   input  logic i_b_end,
   input  logic i_a_lte_b,
   input  logic i_out_almost_full,
   output logic o_pop_a,
   output logic o_pop_b,
   output logic o_issue,
   output logic o_mark
);

   import merge_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_next;
   logic        gap_q;
   logic        can_issue;

   // The kept pair comes back two cycles after an issue
   assign can_issue = ~gap_q & ~i_out_almost_full;

   always_comb begin
      state_next = state;
      o_pop_a    = 1'b0;
      o_pop_b    = 1'b0;
      o_issue    = 1'b0;
      o_mark     = 1'b0;
      case (state)
         IDLE: begin
            if (!i_a_empty || !i_b_empty) begin
               state_next = MERGE;
            end
         end
         MERGE: begin
            if (!i_a_empty && i_a_end) begin
               o_pop_a    = 1'b1;       // Drop marker, no merge
               state_next = DRAIN_B;
            end else if (!i_b_empty && i_b_end) begin
               o_pop_b    = 1'b1;
               state_next = DRAIN_A;
            end else if (!i_a_empty && !i_b_empty && can_issue) begin
               o_issue = 1'b1;
               o_pop_a = i_a_lte_b;
               o_pop_b = ~i_a_lte_b;
            end
         end
         DRAIN_A: begin
            if (!i_a_empty) begin
               if (i_a_end) begin
                  o_pop_a    = 1'b1;
                  state_next = FLUSH;
               end else if (can_issue) begin
                  o_pop_a = 1'b1;
                  o_issue = 1'b1;
               end
            end
         end
         DRAIN_B: begin
            if (!i_b_empty) begin
               if (i_b_end) begin
                  o_pop_b    = 1'b1;
                  state_next = FLUSH;
               end else if (can_issue) begin
                  o_pop_b = 1'b1;
                  o_issue = 1'b1;
               end
            end
         end
         FLUSH: begin
            if (can_issue) begin
               o_issue    = 1'b1;       // Kept pair against filler
               state_next = MARK;
            end
         end
         MARK: begin
            if (can_issue) begin
               o_issue    = 1'b1;
               o_mark     = 1'b1;
               state_next = IDLE;
            end
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= IDLE;
         gap_q <= 1'b0;
      end else begin
         state <= state_next;
         gap_q <= o_issue;
      end
   end

endmodule

// ==== hdl/merge_node.sv ====
`timescale 1ns/1ps

module merge_node #(
   parameter int DATA_WIDTH = merge_pkg::DATA_WIDTH,
   parameter int KEY_WIDTH  = merge_pkg::KEY_WIDTH
) (
   input  logic                    i_clk,
   input  logic                    i_rst,
   input  logic [2*DATA_WIDTH-1:0] i_in_a,
   input  logic                    i_in_a_empty,
   input  logic [2*DATA_WIDTH-1:0] i_in_b,
   input  logic                    i_in_b_empty,
   input  logic                    i_out_ready,
   output logic                    o_in_a_read,
   output logic                    o_in_b_read,
   output logic                    o_out_write,
   output logic [2*DATA_WIDTH-1:0] o_out_data
);

   import merge_pkg::*;

   localparam int BW = 2 * DATA_WIDTH;

   logic [BW-1:0] head_a;
   logic [BW-1:0] head_b;
   logic          a_empty, a_full;
   logic          b_empty, b_full;
   logic          out_empty, out_afull;
   logic          pop_a, pop_b, issue, mark;
   logic          ready_q;
   logic [BW-1:0] new_beat;
   logic [BW-1:0] sel_beat;
   logic          sel_issue, sel_valid, sel_mark;
   logic [BW-1:0] kept;
   logic [BW-1:0] held_in;
   logic          st0_valid, st1_valid;
   logic [BW-1:0] st0_lo, st0_hi, st1_lo, st1_hi;
   logic          mark_d1, mark_d2;
   logic          out_push;
   logic [BW-1:0] out_din;

   assign o_in_a_read = ~i_in_a_empty & ~a_full;
   assign o_in_b_read = ~i_in_b_empty & ~b_full;

   beat_fifo #(.WIDTH(BW), .DEPTH(FIFO_DEPTH), .ALMOST(FIFO_DEPTH - PIPE_DEPTH)) u_fifo_a (
      .i_clk(i_clk), .i_rst(i_rst), .i_push(o_in_a_read), .i_data(i_in_a), .i_pop(pop_a),
      .o_data(head_a), .o_empty(a_empty), .o_full(a_full), .o_almost_full()
   );

   beat_fifo #(.WIDTH(BW), .DEPTH(FIFO_DEPTH), .ALMOST(FIFO_DEPTH - PIPE_DEPTH)) u_fifo_b (
      .i_clk(i_clk), .i_rst(i_rst), .i_push(o_in_b_read), .i_data(i_in_b), .i_pop(pop_b),
      .o_data(head_b), .o_empty(b_empty), .o_full(b_full), .o_almost_full()
   );

   merge_control u_ctrl (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_a_empty(a_empty), .i_b_empty(b_empty),
      .i_a_end(is_marker(head_a)), .i_b_end(is_marker(head_b)),
      .i_a_lte_b(first_key(head_a) <= first_key(head_b)),
      .i_out_almost_full(out_afull),
      .o_pop_a(pop_a), .o_pop_b(pop_b), .o_issue(issue), .o_mark(mark)
   );

   always_comb begin
      if (pop_a) new_beat = head_a;
      else if (pop_b) new_beat = head_b;
      else new_beat = '1;                // Flush filler, all maximum
   end

   // Reversed so kept pair plus new beat is bitonic
   always_ff @(posedge i_clk) begin
      if (issue) begin
         sel_beat <= {new_beat[DATA_WIDTH-1:0], new_beat[BW-1:DATA_WIDTH]};
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ready_q   <= 1'b0;
         sel_issue <= 1'b0;
         sel_valid <= 1'b0;
         sel_mark  <= 1'b0;
         mark_d1   <= 1'b0;
         mark_d2   <= 1'b0;
         kept      <= '0;
      end else begin
         ready_q   <= i_out_ready;
         sel_issue <= issue;
         sel_valid <= issue & ~mark;
         sel_mark  <= issue & mark;
         mark_d1   <= sel_mark;
         mark_d2   <= mark_d1;
         if (mark_d2) kept <= '0;      // Zero pair primes the next merge
         else if (st1_valid) kept <= st1_hi;
      end
   end

   // Bypass the upper pair while it is still in stage 1
   assign held_in = st1_valid ? st1_hi : (mark_d2 ? '0 : kept);

   bitonic_stage #(.DATA_WIDTH(DATA_WIDTH), .KEY_WIDTH(KEY_WIDTH), .STAGE(0)) u_stage0 (
      .i_clk(i_clk), .i_rst(i_rst), .i_stall(~sel_issue), .i_valid(sel_valid),
      .i_lo(held_in), .i_hi(sel_beat),
      .o_valid(st0_valid), .o_lo(st0_lo), .o_hi(st0_hi)
   );

   bitonic_stage #(.DATA_WIDTH(DATA_WIDTH), .KEY_WIDTH(KEY_WIDTH), .STAGE(1)) u_stage1 (
      .i_clk(i_clk), .i_rst(i_rst), .i_stall(~st0_valid), .i_valid(st0_valid),
      .i_lo(st0_lo), .i_hi(st0_hi),
      .o_valid(st1_valid), .o_lo(st1_lo), .o_hi(st1_hi)
   );

   // A zero lower pair only comes out of the priming merge
   assign out_push = (st1_valid & (st1_lo != '0)) | mark_d2;
   assign out_din  = mark_d2 ? '0 : st1_lo;

   assign o_out_write = ready_q & ~out_empty;

   beat_fifo #(.WIDTH(BW), .DEPTH(FIFO_DEPTH), .ALMOST(FIFO_DEPTH - PIPE_DEPTH)) u_fifo_out (
      .i_clk(i_clk), .i_rst(i_rst), .i_push(out_push), .i_data(out_din), .i_pop(o_out_write),
      .o_data(o_out_data), .o_empty(out_empty), .o_full(), .o_almost_full(out_afull)
   );

endmodule

// ==== merge_node.f ====
common/merge_pkg.sv
hdl/beat_fifo.sv
hdl/merge_control.sv
hdl/bitonic_stage.sv
hdl/merge_node.sv
testbench/tb_clock.sv
testbench/merge_node_chk.sv
testbench/merge_node_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the merge node testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f merge_node.f --top-module merge_node_tb -o sim_merge_node \
   && ./obj_dir/sim_merge_node +verilator+error+limit+1000 > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation returned an error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== testbench/merge_node_chk.sv ====
`timescale 1ns/1ps

module merge_node_chk #(
   parameter int DATA_WIDTH = merge_pkg::DATA_WIDTH,
   parameter int KEY_WIDTH  = merge_pkg::KEY_WIDTH
) (
   input logic                    i_clk,
   input logic                    i_rst,
   input logic                    i_in_a_empty,
   input logic                    i_in_b_empty,
   input logic                    i_in_a_read,
   input logic                    i_in_b_read,
   input logic                    i_out_ready,
   input logic                    i_out_write,
   input logic [2*DATA_WIDTH-1:0] i_out_data,
   input logic                    i_mark,
   input logic                    i_out_push,
   input logic [2*DATA_WIDTH-1:0] i_out_din
);

   import merge_pkg::*;

   logic                 seen_data;
   logic                 have_last;   // Inside a merge, a beat already went out
   logic [KEY_WIDTH-1:0] last_key;
   logic [KEY_WIDTH-1:0] key0;
   logic [KEY_WIDTH-1:0] key1;
   logic                 is_end;
   int                   fail_count = 0;

   assign key0   = i_out_data[KEY_WIDTH-1:0];
   assign key1   = i_out_data[DATA_WIDTH+KEY_WIDTH-1:DATA_WIDTH];
   assign is_end = (i_out_data == '0);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         seen_data <= 1'b0;
         have_last <= 1'b0;
         last_key  <= '0;
      end else begin
         if (!i_in_a_empty || !i_in_b_empty) seen_data <= 1'b1;
         if (i_out_write) begin
            have_last <= ~is_end;   // Marker restarts ordering
            if (!is_end) last_key <= key1;
         end
      end
   end

   quiet_after_reset: assert property (@(posedge i_clk) disable iff (i_rst)
      (!seen_data && i_in_a_empty && i_in_b_empty)
         |-> (!i_in_a_read && !i_in_b_read && !i_out_write))
   else begin
      fail_count++;
      $error("Read or write strobe before any source had data");
   end

   beat_sorted: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_out_write && !is_end) |-> (key0 <= key1))
   else begin
      fail_count++;
      $error("Output beat records out of order, %0h then %0h", key0, key1);
   end

   stream_sorted: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_out_write && !is_end && have_last) |-> (key0 >= last_key))
   else begin
      fail_count++;
      $error("Output beat key %0h below previous key %0h", key0, last_key);
   end

   write_needs_ready: assert property (@(posedge i_clk) disable iff (i_rst)
      i_out_write |-> $past(i_out_ready))
   else begin
      fail_count++;
      $error("Output write without ready on the previous cycle");
   end

   read_a_not_empty: assert property (@(posedge i_clk) disable iff (i_rst)
      i_in_a_read |-> !i_in_a_empty)
   else begin
      fail_count++;
      $error("Side A read while upstream is empty");
   end

   read_b_not_empty: assert property (@(posedge i_clk) disable iff (i_rst)
      i_in_b_read |-> !i_in_b_empty)
   else begin
      fail_count++;
      $error("Side B read while upstream is empty");
   end

   // End marker reaches the output FIFO PIPE_DEPTH edges after its issue
   mark_latency: assert property (@(posedge i_clk) disable iff (i_rst)
      i_mark |-> ##(PIPE_DEPTH-1) (i_out_push && i_out_din == '0))
   else begin
      fail_count++;
      $error("End marker not pushed at the expected pipeline depth");
   end

endmodule

// ==== testbench/merge_node_tb.sv ====
`timescale 1ns/1ps

module merge_node_tb;

   import merge_pkg::*;

   localparam int N_EQUAL = 20;
   localparam int N_ONE   = 12;
   localparam int N_LONG  = 30;
   localparam int N_SHORT = 7;
   // Data beats plus one end marker per stream
   localparam int TOTAL_BEATS    = 2 * N_EQUAL + N_ONE + N_LONG + N_SHORT + 6;
   localparam int RESET_MARGIN   = 20;
   localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS * PIPE_DEPTH + 3 * FIFO_DEPTH
                                   + RESET_MARGIN;

   logic                  i_clk;
   logic                  i_rst;
   logic [BEAT_WIDTH-1:0] i_in_a       = '0;
   logic                  i_in_a_empty = 1'b1;
   logic [BEAT_WIDTH-1:0] i_in_b       = '0;
   logic                  i_in_b_empty = 1'b1;
   logic                  i_out_ready  = 1'b0;
   logic                  o_in_a_read;
   logic                  o_in_b_read;
   logic                  o_out_write;
   logic [BEAT_WIDTH-1:0] o_out_data;

   logic [BEAT_WIDTH-1:0] beats_a[$];
   logic [BEAT_WIDTH-1:0] beats_b[$];
   logic [BEAT_WIDTH-1:0] stream_q[$];
   int                    idx_a     = 0;
   int                    idx_b     = 0;
   logic                  src_run   = 1'b0;
   logic                  heavy_bp  = 1'b0;
   int                    out_beats = 0;
   int                    markers   = 0;
   logic [63:0]           out_sum   = '0;
   int                    exp_beats = 0;
   logic [63:0]           exp_sum   = '0;
   int                    errors    = 0;
   int                    test_no   = 0;
   int                    cycles    = 0;

   tb_clock u_clock (.o_clk(i_clk), .o_rst(i_rst));

   merge_node #(.DATA_WIDTH(DATA_WIDTH), .KEY_WIDTH(KEY_WIDTH)) dut (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_in_a(i_in_a), .i_in_a_empty(i_in_a_empty),
      .i_in_b(i_in_b), .i_in_b_empty(i_in_b_empty),
      .i_out_ready(i_out_ready),
      .o_in_a_read(o_in_a_read), .o_in_b_read(o_in_b_read),
      .o_out_write(o_out_write), .o_out_data(o_out_data)
   );

   bind merge_node merge_node_chk #(.DATA_WIDTH(DATA_WIDTH), .KEY_WIDTH(KEY_WIDTH)) u_chk (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_in_a_empty(i_in_a_empty), .i_in_b_empty(i_in_b_empty),
      .i_in_a_read(o_in_a_read), .i_in_b_read(o_in_b_read),
      .i_out_ready(i_out_ready), .i_out_write(o_out_write), .i_out_data(o_out_data),
      .i_mark(mark), .i_out_push(out_push), .i_out_din(out_din)
   );

   // Upstream FIFO models, with occasional empty cycles
   always @(posedge i_clk) begin
      int nxt;
      nxt = o_in_a_read ? idx_a + 1 : idx_a;
      if (!src_run) begin
         idx_a        <= 0;
         i_in_a_empty <= 1'b1;
      end else begin
         idx_a <= nxt;
         if (nxt < beats_a.size() && ($urandom % 8) != 0) begin
            i_in_a       <= beats_a[nxt];
            i_in_a_empty <= 1'b0;
         end else begin
            i_in_a_empty <= 1'b1;
         end
      end
   end

   always @(posedge i_clk) begin
      int nxt;
      nxt = o_in_b_read ? idx_b + 1 : idx_b;
      if (!src_run) begin
         idx_b        <= 0;
         i_in_b_empty <= 1'b1;
      end else begin
         idx_b <= nxt;
         if (nxt < beats_b.size() && ($urandom % 8) != 0) begin
            i_in_b       <= beats_b[nxt];
            i_in_b_empty <= 1'b0;
         end else begin
            i_in_b_empty <= 1'b1;
         end
      end
   end

   always @(posedge i_clk) begin
      if (heavy_bp) i_out_ready <= ($urandom % 3) == 0;   // Mostly low
      else i_out_ready <= ($urandom % 3) != 0;
   end

   // Sink
   always @(posedge i_clk) begin
      if (!i_rst && o_out_write) begin
         if (o_out_data == '0) begin
            markers <= markers + 1;
         end else begin
            out_beats <= out_beats + 1;
            out_sum   <= out_sum + 64'(o_out_data[KEY_WIDTH-1:0])
                         + 64'(o_out_data[DATA_WIDTH+KEY_WIDTH-1:DATA_WIDTH]);
         end
      end
   end

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the merge never produced its end marker", cycles);
         $display("Test failed");
         $finish;
      end
   end

   // Sorted stream of n beats and its end marker into stream_q
   task automatic make_stream(input int n);
      int unsigned keys[$];
      for (int i = 0; i < 2 * n; i++) begin
         keys.push_back(1 + ($urandom % 32'hFFFFFE));
         exp_sum = exp_sum + 64'(keys[i]);
      end
      keys.sort();
      stream_q.delete();
      for (int i = 0; i < n; i++) begin
         stream_q.push_back({DATA_WIDTH'(keys[2*i+1]), DATA_WIDTH'(keys[2*i])});
      end
      stream_q.push_back('0);
      exp_beats = exp_beats + n;
   endtask

   task automatic check_value(input string name, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
      assert (actual == expected)
      else begin
         errors = errors + 1;
         $display("[ERROR] %s: %s expected %0d, actual %0d", name, what, expected, actual);
      end
   endtask

   task automatic run_test(input string name, input int n_a, input int n_b, input logic heavy);
      test_no = test_no + 1;
      make_stream(n_a);
      beats_a = stream_q;
      make_stream(n_b);
      beats_b = stream_q;
      @(posedge i_clk);
      heavy_bp <= heavy;
      src_run  <= 1'b1;
      while (markers < test_no) @(posedge i_clk);
      src_run <= 1'b0;
      // All data beats are out by the time the marker is
      check_value(name, "beats", 64'(exp_beats), 64'(out_beats));
      check_value(name, "key sum", exp_sum, out_sum);
      repeat (FIFO_DEPTH) @(posedge i_clk);   // Quiet time, catches a second marker
      check_value(name, "end markers", 64'(test_no), 64'(markers));
   endtask

   initial begin
      void'($urandom(74));
      while (i_rst !== 1'b0) @(posedge i_clk);
      repeat (3) @(posedge i_clk);
      run_test("equal_lengths", N_EQUAL, N_EQUAL, 1'b0);
      run_test("one_empty", N_ONE, 0, 1'b0);
      run_test("unequal_backpressure", N_LONG, N_SHORT, 1'b1);
      $display("Errors: %0d, assertion failures: %0d", errors, dut.u_chk.fail_count);
      if (errors == 0 && dut.u_chk.fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
   parameter int HALF_PERIOD  = 2,   // 4 ns clock
   parameter int RESET_CYCLES = 4
) (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD) o_clk = ~o_clk;
   end

   initial begin
      o_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_rst <= 1'b0;
   end

endmodule
